// File: design/lsu_isa_pkg.sv
package lsu_isa_pkg;

  localparam int XLEN = 32;

  // Major opcodes handled by the LSU
  typedef enum logic [6:0] {
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011
  } opcode_e;

  // Low two bits of funct3
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } access_size_e;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0]  imm_hi;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo;
    opcode_e     opcode;
  } stype_t;

  // Same instruction word, seen as load or store
  typedef union packed {
    itype_t i;
    stype_t s;
  } inst_u;

  typedef enum logic [3:0] {
    LOAD_ADDR_MISALIGN  = 4'd4,
    STORE_ADDR_MISALIGN = 4'd6
  } except_cause_e;

endpackage

// File: design/lsu_mem_pkg.sv
package lsu_mem_pkg;

  // Bytes per memory word
  localparam int BYTE_LANES = 4;

  // Address bits below the word address
  localparam int LANE_BITS = $clog2(BYTE_LANES);

  localparam int DATA_W = BYTE_LANES * 8;

  typedef logic [BYTE_LANES-1:0] byte_en_t;

  // Full-word and single-lane enable patterns
  localparam byte_en_t BE_WORD = {BYTE_LANES{1'b1}};
  localparam byte_en_t BE_BYTE = byte_en_t'(1);
  localparam byte_en_t BE_HALF = byte_en_t'(3);

endpackage

// File: design/dmem_bus_if.sv
`timescale 1ns/1ns

interface dmem_bus_if #(
  parameter int DMEM_WORDS = 64
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic                              req;
  logic                              ack;
  logic                              we;
  logic [AW-1:0]                     addr;
  logic [lsu_mem_pkg::DATA_W-1:0]    wdata;
  lsu_mem_pkg::byte_en_t             be;
  logic [lsu_mem_pkg::DATA_W-1:0]    rdata;

  modport requester (
    output req, we, addr, wdata, be,
    input  ack, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata, be,
    output ack, rdata
  );

  modport memory (
    input  req, we, addr, wdata, be,
    output ack, rdata
  );

endinterface

// File: design/lsu_issue_stage.sv
`timescale 1ns/1ns

module lsu_issue_stage #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,

  input  logic                                  i_issue_req,
  input  logic [lsu_isa_pkg::XLEN-1:0]          i_issue_inst,
  input  logic [lsu_isa_pkg::XLEN-1:0]          i_issue_rs1,
  input  logic [lsu_isa_pkg::XLEN-1:0]          i_issue_rs2,
  output logic                                  o_issue_ack,

  input  logic                                  i_ld_busy,
  input  logic                                  i_st_busy,
  input  logic [$clog2(DMEM_WORDS)-1:0]         i_st_waddr,

  output logic                                  o_ld_start,
  output logic                                  o_st_start,
  output logic [$clog2(DMEM_WORDS)-1:0]         o_waddr,
  output logic [$clog2(lsu_isa_pkg::XLEN/8)-1:0] o_lane,
  output lsu_isa_pkg::access_size_e             o_size,
  output logic                                  o_signed,
  output logic [4:0]                            o_rd,
  output logic [lsu_isa_pkg::XLEN-1:0]          o_st_data,

  output logic                                  o_except_valid,
  output lsu_isa_pkg::except_cause_e            o_except_cause
);

  localparam int AW = $clog2(DMEM_WORDS);
  localparam int LW = $clog2(lsu_isa_pkg::XLEN / 8);

  typedef enum logic {ST_IDLE, ST_ACK} state_t;

  state_t                          r_state;
  lsu_isa_pkg::inst_u              w_inst;
  logic                            w_is_load;
  logic                            w_is_store;
  logic [lsu_isa_pkg::XLEN-1:0]    w_imm;
  logic [lsu_isa_pkg::XLEN-1:0]    w_addr;
  logic [AW-1:0]                   w_waddr;
  lsu_isa_pkg::access_size_e       w_size;
  logic                            w_misalign;
  logic                            w_hold;
  logic                            w_accept;
  logic                            r_except_pend;

  // --------------------------------------------------------------------------
  // Decode and address generation
  // --------------------------------------------------------------------------
  assign w_inst     = i_issue_inst;
  assign w_is_load  = w_inst.i.opcode == lsu_isa_pkg::OP_LOAD;
  assign w_is_store = w_inst.s.opcode == lsu_isa_pkg::OP_STORE;
  assign w_size     = lsu_isa_pkg::access_size_e'(w_inst.i.funct3[1:0]);

  assign w_imm = w_is_store ?
                 {{20{w_inst.s.imm_hi[6]}}, w_inst.s.imm_hi, w_inst.s.imm_lo} :
                 {{20{w_inst.i.imm[11]}}, w_inst.i.imm};

  assign w_addr  = i_issue_rs1 + w_imm;
  assign w_waddr = w_addr[LW +: AW];

  always_comb begin
    case (w_size)
      lsu_isa_pkg::SIZE_B: w_misalign = 1'b0;
      lsu_isa_pkg::SIZE_H: w_misalign = w_addr[0];
      default:             w_misalign = |w_addr[LW-1:0];
    endcase
  end

  // Ordering hold, exceptions never wait
  always_comb begin
    w_hold = 1'b0;
    if (w_is_store && !w_misalign) begin
      w_hold = i_ld_busy | i_st_busy;
    end else if (w_is_load && !w_misalign) begin
      w_hold = i_ld_busy | (i_st_busy & (i_st_waddr == w_waddr));
    end
  end

  assign w_accept    = (r_state == ST_IDLE) & i_issue_req & !w_hold;
  assign o_issue_ack = r_state == ST_ACK;

  // --------------------------------------------------------------------------
  // Handshake, dispatch strobes and exception pulse
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state        <= ST_IDLE;
      o_ld_start     <= 1'b0;
      o_st_start     <= 1'b0;
      r_except_pend  <= 1'b0;
      o_except_valid <= 1'b0;
    end else begin
      o_ld_start     <= w_accept & w_is_load & !w_misalign;
      o_st_start     <= w_accept & w_is_store & !w_misalign;
      r_except_pend  <= w_accept & (w_is_load | w_is_store) & w_misalign;
      o_except_valid <= r_except_pend;
      case (r_state)
        ST_IDLE: if (w_accept) r_state <= ST_ACK;
        ST_ACK:  if (!i_issue_req) r_state <= ST_IDLE;
        default: r_state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      o_waddr        <= w_waddr;
      o_lane         <= w_addr[LW-1:0];
      o_size         <= w_size;
      o_signed       <= !w_inst.i.funct3[2];
      o_rd           <= w_inst.i.rd;
      o_st_data      <= i_issue_rs2;
      o_except_cause <= w_is_store ? lsu_isa_pkg::STORE_ADDR_MISALIGN :
                                     lsu_isa_pkg::LOAD_ADDR_MISALIGN;
    end
  end

endmodule

// File: design/load_unit.sv
`timescale 1ns/1ns

module load_unit #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                                   i_clk,
  input  logic                                   i_reset_n,

  input  logic                                   i_start,
  input  logic [$clog2(DMEM_WORDS)-1:0]          i_waddr,
  input  logic [lsu_mem_pkg::LANE_BITS-1:0]      i_lane,
  input  lsu_isa_pkg::access_size_e              i_size,
  input  logic                                   i_signed,
  input  logic [4:0]                             i_rd,
  output logic                                   o_busy,

  dmem_bus_if.requester                          mem_bus,

  output logic                                   o_wb_valid,
  output logic [4:0]                             o_wb_rd,
  output logic [lsu_isa_pkg::XLEN-1:0]           o_wb_data
);

  localparam int AW = $clog2(DMEM_WORDS);

  typedef enum logic [1:0] {LD_IDLE, LD_REQ, LD_RELEASE} state_t;

  state_t                              r_state;
  logic [AW-1:0]                       r_waddr;
  logic [lsu_mem_pkg::LANE_BITS-1:0]   r_lane;
  lsu_isa_pkg::access_size_e           r_size;
  logic                                r_signed;
  logic [4:0]                          r_rd;
  logic [lsu_mem_pkg::DATA_W-1:0]      w_shifted;
  logic [lsu_isa_pkg::XLEN-1:0]        w_ext;

  assign o_busy = r_state != LD_IDLE;

  // Read-only requester
  assign mem_bus.req   = r_state == LD_REQ;
  assign mem_bus.we    = 1'b0;
  assign mem_bus.addr  = r_waddr;
  assign mem_bus.wdata = '0;
  assign mem_bus.be    = lsu_mem_pkg::BE_WORD;

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      r_waddr  <= i_waddr;
      r_lane   <= i_lane;
      r_size   <= i_size;
      r_signed <= i_signed;
      r_rd     <= i_rd;
    end
  end

  // Byte extraction and extension
  always_comb begin
    w_shifted = mem_bus.rdata >> {r_lane, 3'b000};
    case (r_size)
      lsu_isa_pkg::SIZE_B:
        w_ext = {{(lsu_isa_pkg::XLEN-8){r_signed & w_shifted[7]}}, w_shifted[7:0]};
      lsu_isa_pkg::SIZE_H:
        w_ext = {{(lsu_isa_pkg::XLEN-16){r_signed & w_shifted[15]}}, w_shifted[15:0]};
      default:
        w_ext = w_shifted;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= LD_IDLE;
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= 1'b0;
      case (r_state)
        LD_IDLE: if (i_start) r_state <= LD_REQ;
        LD_REQ: begin
          if (mem_bus.ack) begin
            o_wb_valid <= r_rd != 5'd0;
            r_state    <= LD_RELEASE;
          end
        end
        LD_RELEASE: if (!mem_bus.ack) r_state <= LD_IDLE;
        default: r_state <= LD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_state == LD_REQ && mem_bus.ack) begin
      o_wb_rd   <= r_rd;
      o_wb_data <= w_ext;
    end
  end

endmodule

// File: design/store_unit.sv
`timescale 1ns/1ns

module store_unit #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                                   i_clk,
  input  logic                                   i_reset_n,

  input  logic                                   i_start,
  input  logic [$clog2(DMEM_WORDS)-1:0]          i_waddr,
  input  logic [lsu_mem_pkg::LANE_BITS-1:0]      i_lane,
  input  lsu_isa_pkg::access_size_e              i_size,
  input  logic [lsu_isa_pkg::XLEN-1:0]           i_data,
  output logic                                   o_busy,

  dmem_bus_if.requester                          mem_bus
);

  localparam int AW = $clog2(DMEM_WORDS);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RELEASE} state_t;

  state_t                          r_state;
  logic [AW-1:0]                   r_waddr;
  lsu_mem_pkg::byte_en_t           r_be;
  logic [lsu_mem_pkg::DATA_W-1:0]  r_wdata;
  lsu_mem_pkg::byte_en_t           w_be;

  always_comb begin
    case (i_size)
      lsu_isa_pkg::SIZE_B: w_be = lsu_mem_pkg::BE_BYTE << i_lane;
      lsu_isa_pkg::SIZE_H: w_be = lsu_mem_pkg::BE_HALF << i_lane;
      default:             w_be = lsu_mem_pkg::BE_WORD;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      r_waddr <= i_waddr;
      r_be    <= w_be;
      r_wdata <= i_data << {i_lane, 3'b000};
    end
  end

  assign o_busy        = r_state != ST_IDLE;
  assign mem_bus.req   = r_state == ST_REQ;
  assign mem_bus.we    = 1'b1;
  assign mem_bus.addr  = r_waddr;
  assign mem_bus.wdata = r_wdata;
  assign mem_bus.be    = r_be;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_IDLE;
    end else begin
      case (r_state)
        ST_IDLE:    if (i_start) r_state <= ST_REQ;
        ST_REQ:     if (mem_bus.ack) r_state <= ST_RELEASE;
        ST_RELEASE: if (!mem_bus.ack) r_state <= ST_IDLE;
        default:    r_state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: design/dmem_arbiter.sv
`timescale 1ns/1ns

module dmem_arbiter #(
  parameter int DMEM_WORDS = 64
) (
  input  logic          i_clk,
  input  logic          i_reset_n,

  dmem_bus_if.arbiter   ld_bus,
  dmem_bus_if.arbiter   st_bus,
  dmem_bus_if.requester mem_bus
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic            r_gnt_ld;
  logic            r_gnt_st;
  logic            r_last_st;
  logic            w_idle;
  logic            w_pick_ld;
  logic            w_pick_st;
  logic [AW-1:0]   w_addr;

  assign w_idle = !r_gnt_ld && !r_gnt_st;

  // Round robin, the last winner loses a tie
  assign w_pick_ld = ld_bus.req & (!st_bus.req | r_last_st);
  assign w_pick_st = st_bus.req & (!ld_bus.req | !r_last_st);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_gnt_ld  <= 1'b0;
      r_gnt_st  <= 1'b0;
      r_last_st <= 1'b1;
    end else if (w_idle) begin
      r_gnt_ld <= w_pick_ld;
      r_gnt_st <= w_pick_st;
      if (w_pick_ld || w_pick_st) begin
        r_last_st <= w_pick_st;
      end
    end else if (!mem_bus.req && !mem_bus.ack) begin
      // Winner finished its full handshake
      r_gnt_ld <= 1'b0;
      r_gnt_st <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Request mux toward memory
  // --------------------------------------------------------------------------
  assign w_addr = r_gnt_st ? st_bus.addr : ld_bus.addr;

  assign mem_bus.req   = (r_gnt_ld & ld_bus.req) | (r_gnt_st & st_bus.req);
  assign mem_bus.we    = r_gnt_st ? st_bus.we    : ld_bus.we;
  assign mem_bus.addr  = w_addr;
  assign mem_bus.wdata = r_gnt_st ? st_bus.wdata : ld_bus.wdata;
  assign mem_bus.be    = r_gnt_st ? st_bus.be    : ld_bus.be;

  // Responses reach the winner only
  assign ld_bus.ack   = r_gnt_ld & mem_bus.ack;
  assign st_bus.ack   = r_gnt_st & mem_bus.ack;
  assign ld_bus.rdata = r_gnt_ld ? mem_bus.rdata : '0;
  assign st_bus.rdata = r_gnt_st ? mem_bus.rdata : '0;

endmodule

// File: design/dmem_ram.sv
`timescale 1ns/1ns

module dmem_ram #(
  parameter int DMEM_WORDS = 64
) (
  input  logic        i_clk,
  input  logic        i_reset_n,

  dmem_bus_if.memory  mem_bus
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic [lsu_mem_pkg::DATA_W-1:0]  r_mem [DMEM_WORDS];
  logic [lsu_mem_pkg::DATA_W-1:0]  r_rdata;
  logic                            r_ack;
  logic [AW-1:0]                   w_addr;
  logic                            w_take;

  assign w_addr        = mem_bus.addr;
  assign w_take        = mem_bus.req & !r_ack;
  assign mem_bus.ack   = r_ack;
  assign mem_bus.rdata = r_rdata;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ack <= 1'b0;
    end else if (w_take) begin
      r_ack <= 1'b1;
    end else if (!mem_bus.req) begin
      r_ack <= 1'b0;
    end
  end

  // Read and byte write on the edge that raises ack
  always_ff @(posedge i_clk) begin
    if (w_take) begin
      r_rdata <= r_mem[w_addr];
      if (mem_bus.we) begin
        for (int b = 0; b < lsu_mem_pkg::BYTE_LANES; b++) begin
          if (mem_bus.be[b]) r_mem[w_addr][b*8 +: 8] <= mem_bus.wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

// File: design/lsu_core.sv
`timescale 1ns/1ns

module lsu_core #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                            i_clk,
  input  logic                            i_reset_n,

  input  logic                            i_issue_req,
  input  logic [lsu_isa_pkg::XLEN-1:0]    i_issue_inst,
  input  logic [lsu_isa_pkg::XLEN-1:0]    i_issue_rs1,
  input  logic [lsu_isa_pkg::XLEN-1:0]    i_issue_rs2,
  output logic                            o_issue_ack,

  output logic                            o_wb_valid,
  output logic [4:0]                      o_wb_rd,
  output logic [lsu_isa_pkg::XLEN-1:0]    o_wb_data,

  output logic                            o_except_valid,
  output lsu_isa_pkg::except_cause_e      o_except_cause
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic                                w_ld_start;
  logic                                w_st_start;
  logic                                w_ld_busy;
  logic                                w_st_busy;
  logic [AW-1:0]                       w_waddr;
  logic [lsu_mem_pkg::LANE_BITS-1:0]   w_lane;
  lsu_isa_pkg::access_size_e           w_size;
  logic                                w_signed;
  logic [4:0]                          w_rd;
  logic [lsu_isa_pkg::XLEN-1:0]        w_st_data;

  dmem_bus_if #(.DMEM_WORDS(DMEM_WORDS)) ld_bus ();
  dmem_bus_if #(.DMEM_WORDS(DMEM_WORDS)) st_bus ();
  dmem_bus_if #(.DMEM_WORDS(DMEM_WORDS)) mem_bus ();

  lsu_issue_stage #(.DMEM_WORDS(DMEM_WORDS)) issue_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue_req    (i_issue_req),
    .i_issue_inst   (i_issue_inst),
    .i_issue_rs1    (i_issue_rs1),
    .i_issue_rs2    (i_issue_rs2),
    .o_issue_ack    (o_issue_ack),
    .i_ld_busy      (w_ld_busy),
    .i_st_busy      (w_st_busy),
    .i_st_waddr     (st_bus.addr),
    .o_ld_start     (w_ld_start),
    .o_st_start     (w_st_start),
    .o_waddr        (w_waddr),
    .o_lane         (w_lane),
    .o_size         (w_size),
    .o_signed       (w_signed),
    .o_rd           (w_rd),
    .o_st_data      (w_st_data),
    .o_except_valid (o_except_valid),
    .o_except_cause (o_except_cause)
  );

  load_unit #(.DMEM_WORDS(DMEM_WORDS)) load_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_start    (w_ld_start),
    .i_waddr    (w_waddr),
    .i_lane     (w_lane),
    .i_size     (w_size),
    .i_signed   (w_signed),
    .i_rd       (w_rd),
    .o_busy     (w_ld_busy),
    .mem_bus    (ld_bus.requester),
    .o_wb_valid (o_wb_valid),
    .o_wb_rd    (o_wb_rd),
    .o_wb_data  (o_wb_data)
  );

  store_unit #(.DMEM_WORDS(DMEM_WORDS)) store_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_start   (w_st_start),
    .i_waddr   (w_waddr),
    .i_lane    (w_lane),
    .i_size    (w_size),
    .i_data    (w_st_data),
    .o_busy    (w_st_busy),
    .mem_bus   (st_bus.requester)
  );

  dmem_arbiter #(.DMEM_WORDS(DMEM_WORDS)) arbiter_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .ld_bus    (ld_bus.arbiter),
    .st_bus    (st_bus.arbiter),
    .mem_bus   (mem_bus.requester)
  );

  dmem_ram #(.DMEM_WORDS(DMEM_WORDS)) ram_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .mem_bus   (mem_bus.memory)
  );

endmodule

// File: bench/lsu_ref_model.svh
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

localparam int MODEL_BYTES = DMEM_WORDS * lsu_mem_pkg::BYTE_LANES;

// Byte image of the data memory
logic [7:0]  model_mem [MODEL_BYTES];
logic [31:0] rng_state = 32'd16;

// xorshift32 step
function automatic logic [31:0] rand32();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// Size 0, 1, 2 writes 1, 2 or 4 bytes little endian
task automatic model_store(input logic [31:0] addr, input logic [1:0] size,
                           input logic [31:0] data);
  int base;
  int b;
  base = addr % MODEL_BYTES;
  for (b = 0; b < (1 << size); b++) begin
    model_mem[base + b] = data[8*b +: 8];
  end
endtask

// Expected register value of a load, funct3[2] selects zero extension
function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [2:0] funct3);
  int          base;
  int          nbytes;
  int          b;
  logic [31:0] raw;
  base   = addr % MODEL_BYTES;
  nbytes = 1 << funct3[1:0];
  raw    = '0;
  for (b = 0; b < nbytes; b++) begin
    raw[8*b +: 8] = model_mem[base + b];
  end
  if (!funct3[2] && nbytes < 4 && raw[8*nbytes-1]) begin
    raw = raw | (~32'd0 << (8 * nbytes));
  end
  return raw;
endfunction

`endif

// File: bench/lsu_core_tb.sv
`timescale 1ns/1ns

module lsu_core_tb;

  localparam int DMEM_WORDS  = 64;
  localparam int N_RANDOM    = 300;
  // Fill, readback, sub-word, misaligned, x0 and random phases
  localparam int N_INSTR     = 2 * DMEM_WORDS + 72 + 20 + 5 + N_RANDOM;
  localparam int WATCHDOG_NS = N_INSTR * 40 * 20;
  localparam logic [3:0] CAUSE_LD = 4'd4;
  localparam logic [3:0] CAUSE_ST = 4'd6;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_exp_t;

  logic        i_clk;
  logic        i_reset_n;
  logic        i_issue_req;
  logic [31:0] i_issue_inst;
  logic [31:0] i_issue_rs1;
  logic [31:0] i_issue_rs2;
  logic        o_issue_ack;
  logic        o_wb_valid;
  logic [4:0]  o_wb_rd;
  logic [31:0] o_wb_data;
  logic        o_except_valid;
  logic [3:0]  o_except_cause;

  wb_exp_t     exp_wb_q [$];
  logic [3:0]  exp_exc_q [$];

  `include "lsu_ref_model.svh"

  lsu_core #(.DMEM_WORDS(DMEM_WORDS)) lsu_core_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue_req    (i_issue_req),
    .i_issue_inst   (i_issue_inst),
    .i_issue_rs1    (i_issue_rs1),
    .i_issue_rs2    (i_issue_rs2),
    .o_issue_ack    (o_issue_ack),
    .o_wb_valid     (o_wb_valid),
    .o_wb_rd        (o_wb_rd),
    .o_wb_data      (o_wb_data),
    .o_except_valid (o_except_valid),
    .o_except_cause (o_except_cause)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // Instruction building
  // --------------------------------------------------------------------------
  function automatic logic [31:0] encode_load(input logic [2:0] funct3, input logic [4:0] rd,
                                              input logic [11:0] imm);
    lsu_isa_pkg::itype_t f;
    f.imm    = imm;
    f.rs1    = 5'd1;
    f.funct3 = funct3;
    f.rd     = rd;
    f.opcode = lsu_isa_pkg::OP_LOAD;
    return f;
  endfunction

  function automatic logic [31:0] encode_store(input logic [2:0] funct3, input logic [11:0] imm);
    lsu_isa_pkg::stype_t f;
    f.imm_hi = imm[11:5];
    f.rs2    = 5'd2;
    f.rs1    = 5'd1;
    f.funct3 = funct3;
    f.imm_lo = imm[4:0];
    f.opcode = lsu_isa_pkg::OP_STORE;
    return f;
  endfunction

  // Small signed offset with rs1 making up the rest
  function automatic logic [11:0] random_imm();
    logic [31:0] r;
    r = rand32();
    return {{5{r[6]}}, r[6:0]};
  endfunction

  function automatic logic [4:0] rand_rd();
    return 5'(rand32() % 31) + 5'd1;
  endfunction

  function automatic logic misaligned(input logic [31:0] addr, input logic [1:0] size);
    case (size)
      2'd0:    return 1'b0;
      2'd1:    return addr[0];
      default: return addr[1:0] != 2'b00;
    endcase
  endfunction

  function automatic logic [31:0] pick_addr(input int word, input logic [1:0] size,
                                            input logic [1:0] lane);
    case (size)
      2'd0:    return word * 4 + lane;
      2'd1:    return word * 4 + {lane[1], 1'b0};
      default: return word * 4;
    endcase
  endfunction

  // Four-phase issue handshake
  task automatic issue_instr(input logic [31:0] inst, input logic [31:0] rs1,
                             input logic [31:0] rs2, input logic expect_exc);
    @(posedge i_clk);
    i_issue_req  <= 1'b1;
    i_issue_inst <= inst;
    i_issue_rs1  <= rs1;
    i_issue_rs2  <= rs2;
    @(negedge i_clk);
    while (!o_issue_ack) @(negedge i_clk);
    @(posedge i_clk);
    i_issue_req <= 1'b0;
    @(negedge i_clk);
    // Exception pulse belongs to the cycle after the ack rose
    if (expect_exc) check_value("o_except_valid", o_except_valid, 1);
    while (o_issue_ack) @(negedge i_clk);
  endtask

  task automatic do_load(input logic [2:0] funct3, input logic [4:0] rd,
                         input logic [31:0] addr);
    logic [11:0] imm;
    logic [31:0] rs1;
    logic        bad;
    wb_exp_t     exp_wb;
    imm = random_imm();
    rs1 = addr - {{20{imm[11]}}, imm};
    bad = misaligned(addr, funct3[1:0]);
    if (bad) begin
      exp_exc_q.push_back(CAUSE_LD);
    end else if (rd != 5'd0) begin
      exp_wb.rd   = rd;
      exp_wb.data = ref_load(addr, funct3);
      exp_wb_q.push_back(exp_wb);
    end
    issue_instr(encode_load(funct3, rd, imm), rs1, rand32(), bad);
  endtask

  task automatic do_store(input logic [2:0] funct3, input logic [31:0] addr,
                          input logic [31:0] data);
    logic [11:0] imm;
    logic [31:0] rs1;
    logic        bad;
    imm = random_imm();
    rs1 = addr - {{20{imm[11]}}, imm};
    bad = misaligned(addr, funct3[1:0]);
    if (bad) exp_exc_q.push_back(CAUSE_ST);
    else model_store(addr, funct3[1:0], data);
    issue_instr(encode_store(funct3, imm), rs1, data, bad);
  endtask

  // LB, LBU, LH, LHU and LW around one lane
  task automatic load_all_sizes(input int base, input int lane);
    do_load(3'd0, rand_rd(), base + lane);
    do_load(3'd4, rand_rd(), base + lane);
    do_load(3'd1, rand_rd(), base + (lane & 2));
    do_load(3'd5, rand_rd(), base + (lane & 2));
    do_load(3'd2, rand_rd(), base);
  endtask

  task automatic sub_word_pass(input int word);
    int lane;
    for (lane = 0; lane < 4; lane++) begin
      do_store(3'd0, word * 4 + lane, rand32());
      load_all_sizes(word * 4, lane);
    end
    for (lane = 0; lane < 4; lane += 2) begin
      do_store(3'd1, word * 4 + lane, rand32());
      load_all_sizes(word * 4, lane);
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    while ((exp_wb_q.size() != 0 || exp_exc_q.size() != 0) && cycles < 100) begin
      @(negedge i_clk);
      cycles++;
    end
    repeat (20) @(negedge i_clk);
  endtask

  // --------------------------------------------------------------------------
  // Response comparison
  // --------------------------------------------------------------------------
  initial begin : compare_responses
    wb_exp_t exp_wb;
    forever begin
      @(negedge i_clk);
      if (i_reset_n && o_wb_valid) begin
        if (exp_wb_q.size() == 0) begin
          $display("Writeback to x%0d arrived with none expected", o_wb_rd);
          abort_run();
        end
        exp_wb = exp_wb_q.pop_front();
        check_value("o_wb_rd", o_wb_rd, exp_wb.rd);
        check_value("o_wb_data", o_wb_data, exp_wb.data);
      end
      if (i_reset_n && o_except_valid) begin
        if (exp_exc_q.size() == 0) begin
          $display("Exception pulse arrived with none expected");
          abort_run();
        end
        check_value("o_except_cause", o_except_cause, exp_exc_q.pop_front());
      end
    end
  end

  initial begin : handshake_monitor
    logic prev_ack;
    logic prev_req;
    prev_ack = 1'b0;
    prev_req = 1'b0;
    forever begin
      @(negedge i_clk);
      if (!i_reset_n) begin
        check_value("o_issue_ack", o_issue_ack, 0);
        check_value("o_wb_valid", o_wb_valid, 0);
        check_value("o_except_valid", o_except_valid, 0);
      end else if (prev_ack && !o_issue_ack && prev_req) begin
        $display("o_issue_ack fell while i_issue_req was still high");
        abort_run();
      end else if (!prev_ack && o_issue_ack && !prev_req) begin
        $display("o_issue_ack rose with no request pending");
        abort_run();
      end
      prev_ack = o_issue_ack;
      prev_req = i_issue_req;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    abort_run();
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    int          i;
    int          word;
    int          last_word;
    logic [31:0] r;
    logic [1:0]  sz;
    i_reset_n    = 1'b0;
    i_issue_req  = 1'b0;
    i_issue_inst = '0;
    i_issue_rs1  = '0;
    i_issue_rs2  = '0;
    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;
    repeat (4) @(posedge i_clk);

    for (i = 0; i < DMEM_WORDS; i++) do_store(3'd2, i * 4, rand32());
    for (i = 0; i < DMEM_WORDS; i++) do_load(3'd2, 5'(i % 31 + 1), i * 4);

    sub_word_pass(3);
    sub_word_pass(DMEM_WORDS - 1);

    // Misaligned accesses on word 5 with a full-word read after each
    for (i = 1; i < 4; i++) begin
      if (i != 2) begin
        do_load(3'd1, rand_rd(), 20 + i);
        do_load(3'd2, rand_rd(), 20);
        do_store(3'd1, 20 + i, rand32());
        do_load(3'd2, rand_rd(), 20);
      end
      do_load(3'd2, rand_rd(), 20 + i);
      do_load(3'd2, rand_rd(), 20);
      do_store(3'd2, 20 + i, rand32());
      do_load(3'd2, rand_rd(), 20);
    end

    do_load(3'd2, 5'd0, 28);
    do_load(3'd0, 5'd0, 29);
    do_load(3'd5, 5'd0, 30);
    do_load(3'd4, 5'd0, 31);
    do_load(3'd2, rand_rd(), 28);

    // Random mix where loads often follow a store to the same word
    last_word = 0;
    for (i = 0; i < N_RANDOM; i++) begin
      r  = rand32();
      sz = 2'(r[4:3] % 3);
      if (r[2:0] < 3) begin
        word      = r[15:8] % DMEM_WORDS;
        last_word = word;
        do_store({1'b0, sz}, pick_addr(word, sz, r[6:5]), rand32());
      end else begin
        word = (r[2:0] >= 6) ? last_word : r[15:8] % DMEM_WORDS;
        do_load({r[7] & (sz != 2'd2), sz}, r[20:16], pick_addr(word, sz, r[6:5]));
      end
    end

    wait_idle();
    if (exp_wb_q.size() != 0 || exp_exc_q.size() != 0) begin
      $display("Missing %0d writeback(s) and %0d exception(s)",
               exp_wb_q.size(), exp_exc_q.size());
      abort_run();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

// File: files.f
+incdir+bench
design/lsu_isa_pkg.sv
design/lsu_mem_pkg.sv
design/dmem_bus_if.sv
design/lsu_issue_stage.sv
design/load_unit.sv
design/store_unit.sv
design/dmem_arbiter.sv
design/dmem_ram.sv
design/lsu_core.sv
bench/lsu_core_tb.sv
